/* sim.f */
hdl/rv_pkg.sv
hdl/gpr_file.sv
hdl/csr_file.sv
hdl/idu_core.sv
hdl/idu.sv
hdl/ifu.sv
hdl/exu.sv
hdl/rv_core.sv
verif/rv_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module rv_core_tb -f sim.f -o rv_core_sim &&
./obj_dir/rv_core_sim | tee /dev/stderr | grep -qF '*** PASSED ***' &&
echo "simulation run ok" || { echo "simulation run not ok"; exit 1; }

/* verif/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

    localparam logic [31:0] reset_pc = 32'h0000_0100;
    localparam int n_inst     = 60; // commits checked over all tests.
    localparam int n_tests    = 6;
    localparam int max_cycles = 2 * (8 * n_inst + 16 * n_tests);

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] inst_addr;
    logic [31:0] inst_data;
    logic        commit;
    logic [31:0] commit_pc;
    logic [4:0]  commit_rd;
    logic [31:0] commit_data;
    logic        commit_we;

    logic [31:0] imem [0:255];
    logic [31:0] prog [$];
    string       test_name = "none";
    integer      seed = 34;
    int          cycles = 0;

    rv_core #(
        .reset_pc(reset_pc)
    ) rv_core_inst (
        .clk        (clk),
        .rst        (rst),
        .inst_addr  (inst_addr),
        .inst_data  (inst_data),
        .commit     (commit),
        .commit_pc  (commit_pc),
        .commit_rd  (commit_rd),
        .commit_data(commit_data),
        .commit_we  (commit_we)
    );

    assign inst_data = imem[inst_addr[9:2]]; // word addressed, combinational read.

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: no progress after %0d cycles in test %s", cycles, test_name);
            $display("*** FAILED ***");
            $fatal(1, "simulation timed out");
        end
    end

    // addi x0, x0, idx; a stray fetch does nothing.
    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return {4'h0, idx, 20'h00013};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return i_word(imm, rs1, 3'b000, rd);
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] csr_word(input logic [11:0] csr, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
        return {csr, rs1, f3, rd, 7'b1110011};
    endfunction

    function automatic logic [31:0] slot_addr(input int n);
        return reset_pc + 32'(4 * n);
    endfunction

    task automatic fill_memory();
        for (int k = 0; k < 256; k++) begin
            imem[k] <= fill_word(k[7:0]);
        end
    endtask

    // memory is rewritten while the core sits in reset.
    task automatic reset_core();
        logic [7:0] base;
        base = reset_pc[9:2];
        @(posedge clk);
        rst <= 1'b1;
        fill_memory();
        for (int k = 0; k < prog.size(); k++) begin
            imem[base + 8'(k)] <= prog[k];
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic wait_commit();
        @(posedge clk);
        while (!commit) @(posedge clk);
    endtask

    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error in test %s, %s: expected %h, actual %h",
                     test_name, field, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "check failed in test %s", test_name);
        end
    endtask

    // rd and data are skipped for branches, ecall and mret.
    task automatic expect_commit(input logic [31:0] pc, input logic [4:0] rd,
                                 input logic [31:0] data, input logic we,
                                 input logic has_value);
        wait_commit();
        check_value("commit_pc", pc, commit_pc);
        check_value("commit_we", {31'b0, we}, {31'b0, commit_we});
        if (has_value) begin
            check_value("commit_rd", {27'b0, rd}, {27'b0, commit_rd});
            check_value("commit_data", data, commit_data);
        end
    endtask

    task automatic arith_test();
        logic [31:0] a;
        logic [31:0] b;
        test_name = "arith";
        a = 32'd100;
        b = 32'hffff_fff9; // -7.
        prog = {};
        prog.push_back(addi(5'd1, 5'd0, 12'd100));
        prog.push_back(addi(5'd2, 5'd0, 12'hff9));
        prog.push_back(r_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        prog.push_back(r_word(7'h20, 5'd1, 5'd2, 3'b000, 5'd4)); // x2 - x1.
        prog.push_back(r_word(7'h00, 5'd2, 5'd1, 3'b100, 5'd5));
        prog.push_back(r_word(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
        prog.push_back(r_word(7'h00, 5'd2, 5'd1, 3'b111, 5'd7));
        prog.push_back(r_word(7'h00, 5'd1, 5'd2, 3'b010, 5'd8)); // x2 < x1.
        prog.push_back(r_word(7'h00, 5'd2, 5'd1, 3'b010, 5'd9)); // x1 < x2.
        prog.push_back(i_word(12'hffd, 5'd2, 3'b010, 5'd10));  // slti against -3.
        prog.push_back(i_word(12'hfff, 5'd1, 3'b100, 5'd11));
        prog.push_back(i_word(12'h0f0, 5'd2, 3'b110, 5'd12));
        prog.push_back(i_word(12'h0ff, 5'd2, 3'b111, 5'd13));
        prog.push_back(addi(5'd0, 5'd1, 12'd5));
        reset_core();
        expect_commit(slot_addr(0), 5'd1, a, 1'b1, 1'b1);
        expect_commit(slot_addr(1), 5'd2, b, 1'b1, 1'b1);
        expect_commit(slot_addr(2), 5'd3, a + b, 1'b1, 1'b1);
        expect_commit(slot_addr(3), 5'd4, b - a, 1'b1, 1'b1);
        expect_commit(slot_addr(4), 5'd5, a ^ b, 1'b1, 1'b1);
        expect_commit(slot_addr(5), 5'd6, a | b, 1'b1, 1'b1);
        expect_commit(slot_addr(6), 5'd7, a & b, 1'b1, 1'b1);
        expect_commit(slot_addr(7), 5'd8, {31'b0, $signed(b) < $signed(a)}, 1'b1, 1'b1);
        expect_commit(slot_addr(8), 5'd9, {31'b0, $signed(a) < $signed(b)}, 1'b1, 1'b1);
        expect_commit(slot_addr(9), 5'd10, {31'b0, $signed(b) < -32'sd3}, 1'b1, 1'b1);
        expect_commit(slot_addr(10), 5'd11, a ^ 32'hffff_ffff, 1'b1, 1'b1);
        expect_commit(slot_addr(11), 5'd12, b | 32'h0000_00f0, 1'b1, 1'b1);
        expect_commit(slot_addr(12), 5'd13, b & 32'h0000_00ff, 1'b1, 1'b1);
        expect_commit(slot_addr(13), 5'd0, a + 32'd5, 1'b0, 1'b1);
    endtask

    task automatic upper_test();
        test_name = "upper";
        prog = {};
        prog.push_back({20'h12345, 5'd1, 7'b0110111});
        prog.push_back({20'h00010, 5'd2, 7'b0010111});
        prog.push_back({20'hfffff, 5'd3, 7'b0010111});
        reset_core();
        expect_commit(slot_addr(0), 5'd1, {20'h12345, 12'h0}, 1'b1, 1'b1);
        expect_commit(slot_addr(1), 5'd2, slot_addr(1) + {20'h00010, 12'h0}, 1'b1, 1'b1);
        expect_commit(slot_addr(2), 5'd3, slot_addr(2) + {20'hfffff, 12'h0}, 1'b1, 1'b1);
    endtask

    task automatic branch_test();
        logic [31:0] marker;
        test_name = "branch";
        marker = addi(5'd5, 5'd0, 12'd1); // only reached if a branch goes wrong.
        prog = {};
        prog.push_back(addi(5'd1, 5'd0, 12'd3));
        prog.push_back(addi(5'd2, 5'd0, 12'd3));
        prog.push_back(b_word(13'd8, 5'd2, 5'd1, 3'b000));  // beq taken.
        prog.push_back(marker);
        prog.push_back(b_word(13'd8, 5'd2, 5'd1, 3'b001));  // bne not taken.
        prog.push_back(b_word(13'd8, 5'd0, 5'd1, 3'b000));  // beq not taken.
        prog.push_back(b_word(13'd12, 5'd0, 5'd1, 3'b001)); // bne taken.
        prog.push_back(marker);
        prog.push_back(marker);
        prog.push_back(j_word(21'd12, 5'd6));
        prog.push_back(marker);
        prog.push_back(marker);
        prog.push_back(addi(5'd7, 5'd0, 12'd9));
        reset_core();
        expect_commit(slot_addr(0), 5'd1, 32'd3, 1'b1, 1'b1);
        expect_commit(slot_addr(1), 5'd2, 32'd3, 1'b1, 1'b1);
        expect_commit(slot_addr(2), 5'd0, 32'd0, 1'b0, 1'b0);
        expect_commit(slot_addr(2) + 32'd8, 5'd0, 32'd0, 1'b0, 1'b0);
        expect_commit(slot_addr(5), 5'd0, 32'd0, 1'b0, 1'b0);
        expect_commit(slot_addr(6), 5'd0, 32'd0, 1'b0, 1'b0);
        expect_commit(slot_addr(6) + 32'd12, 5'd6, slot_addr(9) + 32'd4, 1'b1, 1'b1);
        expect_commit(slot_addr(9) + 32'd12, 5'd7, 32'd9, 1'b1, 1'b1);
    endtask

    task automatic csr_test();
        test_name = "csr";
        prog = {};
        prog.push_back(addi(5'd1, 5'd0, 12'h2c0));
        prog.push_back(csr_word(12'h305, 5'd1, 3'b001, 5'd2));  // csrrw mtvec.
        prog.push_back(csr_word(12'h305, 5'd0, 3'b010, 5'd3));  // csrrs mtvec, x0.
        prog.push_back(csr_word(12'h305, 5'd0, 3'b010, 5'd4));
        prog.push_back(csr_word(12'h341, 5'd20, 3'b101, 5'd5)); // csrrwi mepc, 20.
        prog.push_back(csr_word(12'h341, 5'd0, 3'b010, 5'd6));
        reset_core();
        expect_commit(slot_addr(0), 5'd1, 32'h2c0, 1'b1, 1'b1);
        expect_commit(slot_addr(1), 5'd2, 32'd0, 1'b1, 1'b1);
        expect_commit(slot_addr(2), 5'd3, 32'h2c0, 1'b1, 1'b1);
        expect_commit(slot_addr(3), 5'd4, 32'h2c0, 1'b1, 1'b1);
        expect_commit(slot_addr(4), 5'd5, 32'd0, 1'b1, 1'b1);
        expect_commit(slot_addr(5), 5'd6, 32'd20, 1'b1, 1'b1);
    endtask

    task automatic trap_test();
        logic [31:0] handler;
        test_name = "trap";
        handler = slot_addr(5);
        prog = {};
        prog.push_back(addi(5'd1, 5'd0, handler[11:0]));
        prog.push_back(csr_word(12'h305, 5'd1, 3'b001, 5'd0));
        prog.push_back(32'h0000_0073);                         // ecall.
        prog.push_back(addi(5'd2, 5'd0, 12'd5));               // return point.
        prog.push_back(j_word(21'd0, 5'd0));
        prog.push_back(csr_word(12'h342, 5'd0, 3'b010, 5'd3)); // handler reads mcause.
        prog.push_back(csr_word(12'h341, 5'd0, 3'b010, 5'd4));
        prog.push_back(addi(5'd4, 5'd4, 12'd4));
        prog.push_back(csr_word(12'h341, 5'd4, 3'b001, 5'd0));
        prog.push_back(32'h3020_0073);                         // mret.
        reset_core();
        expect_commit(slot_addr(0), 5'd1, handler, 1'b1, 1'b1);
        expect_commit(slot_addr(1), 5'd0, 32'd0, 1'b0, 1'b1);
        expect_commit(slot_addr(2), 5'd0, 32'd0, 1'b0, 1'b0);
        expect_commit(handler, 5'd3, 32'd11, 1'b1, 1'b1);
        expect_commit(slot_addr(6), 5'd4, slot_addr(2), 1'b1, 1'b1);
        expect_commit(slot_addr(7), 5'd4, slot_addr(2) + 32'd4, 1'b1, 1'b1);
        expect_commit(slot_addr(8), 5'd0, slot_addr(2), 1'b0, 1'b1);
        expect_commit(slot_addr(9), 5'd0, 32'd0, 1'b0, 1'b0);
        expect_commit(slot_addr(2) + 32'd4, 5'd2, 32'd5, 1'b1, 1'b1);
    endtask

    task automatic random_test();
        logic [11:0] imms [0:19];
        logic [31:0] sum;
        test_name = "random";
        prog = {};
        for (int k = 0; k < 20; k++) begin
            imms[k] = 12'($random(seed));
            prog.push_back(addi(5'd1, 5'd1, imms[k]));
        end
        reset_core();
        sum = 32'd0;
        for (int k = 0; k < 20; k++) begin
            sum = sum + {{20{imms[k][11]}}, imms[k]}; // sign-extended immediate.
            expect_commit(slot_addr(k), 5'd1, sum, 1'b1, 1'b1);
        end
    endtask

    initial begin
        rst <= 1'b1;
        fill_memory();
        arith_test();
        upper_test();
        branch_test();
        csr_test();
        trap_test();
        random_test();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* hdl/rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                    clk,
    input  logic                    rst,
    output logic [rv_pkg::xlen-1:0] inst_addr,
    input  logic [rv_pkg::xlen-1:0] inst_data,
    output logic                    commit,
    output logic [rv_pkg::xlen-1:0] commit_pc,
    output logic [4:0]              commit_rd,
    output logic [rv_pkg::xlen-1:0] commit_data,
    output logic                    commit_we
);

    import rv_pkg::*;

    logic            inst_valid;
    logic            inst_ready;
    logic [xlen-1:0] inst;
    logic [xlen-1:0] fetch_pc;

    logic            dec_valid;
    logic            dec_ready;
    opcode_t         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    inst_type_t      inst_type;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [4:0]      rd;
    logic [xlen-1:0] dec_pc;
    logic [xlen-1:0] csr_r;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;

    // write-back from execute.
    logic [xlen-1:0] srd;
    logic            gpr_w_en;
    logic [xlen-1:0] csr_wdata;
    logic            csr_w_en;
    logic            is_intr;
    logic [xlen-1:0] intr_code;
    logic            redirect;
    logic [xlen-1:0] next_pc;

    ifu #(
        .reset_pc(reset_pc)
    ) ifu_inst (
        .clk       (clk),
        .rst       (rst),
        .redirect  (redirect),
        .next_pc   (next_pc),
        .inst_addr (inst_addr),
        .inst_data (inst_data),
        .inst_valid(inst_valid),
        .inst_ready(inst_ready),
        .inst      (inst),
        .pc        (fetch_pc)
    );

    idu idu_inst (
        .clk       (clk),
        .rst       (rst),
        .inst_valid(inst_valid),
        .inst_ready(inst_ready),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .inst      (inst),
        .pc        (fetch_pc),
        .opcode    (opcode),
        .funct3    (funct3),
        .funct7    (funct7),
        .inst_type (inst_type),
        .imm       (imm),
        .src1      (src1),
        .src2      (src2),
        .rd        (rd),
        .dec_pc    (dec_pc),
        .csr_r     (csr_r),
        .mtvec     (mtvec),
        .mepc      (mepc),
        .srd       (srd),
        .gpr_w_en  (gpr_w_en),
        .csr_wdata (csr_wdata),
        .csr_w_en  (csr_w_en),
        .is_intr   (is_intr),
        .intr_code (intr_code)
    );

    exu exu_inst (
        .clk        (clk),
        .rst        (rst),
        .dec_valid  (dec_valid),
        .dec_ready  (dec_ready),
        .opcode     (opcode),
        .funct3     (funct3),
        .funct7     (funct7),
        .inst_type  (inst_type),
        .imm        (imm),
        .src1       (src1),
        .src2       (src2),
        .rd         (rd),
        .pc         (dec_pc),
        .csr_r      (csr_r),
        .mtvec      (mtvec),
        .mepc       (mepc),
        .srd        (srd),
        .gpr_w_en   (gpr_w_en),
        .csr_wdata  (csr_wdata),
        .csr_w_en   (csr_w_en),
        .is_intr    (is_intr),
        .intr_code  (intr_code),
        .redirect   (redirect),
        .next_pc    (next_pc),
        .commit     (commit),
        .commit_pc  (commit_pc),
        .commit_rd  (commit_rd),
        .commit_data(commit_data),
        .commit_we  (commit_we)
    );

endmodule

/* hdl/exu.sv */
`timescale 1ns/1ps

module exu (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    dec_valid,
    output logic                    dec_ready,
    input  rv_pkg::opcode_t         opcode,
    input  logic [2:0]              funct3,
    input  logic [6:0]              funct7,
    input  rv_pkg::inst_type_t      inst_type,
    input  logic [rv_pkg::xlen-1:0] imm,
    input  logic [rv_pkg::xlen-1:0] src1,
    input  logic [rv_pkg::xlen-1:0] src2,
    input  logic [4:0]              rd,
    input  logic [rv_pkg::xlen-1:0] pc,
    input  logic [rv_pkg::xlen-1:0] csr_r,
    input  logic [rv_pkg::xlen-1:0] mtvec,
    input  logic [rv_pkg::xlen-1:0] mepc,
    output logic [rv_pkg::xlen-1:0] srd,
    output logic                    gpr_w_en,
    output logic [rv_pkg::xlen-1:0] csr_wdata,
    output logic                    csr_w_en,
    output logic                    is_intr,
    output logic [rv_pkg::xlen-1:0] intr_code,
    output logic                    redirect,
    output logic [rv_pkg::xlen-1:0] next_pc,
    output logic                    commit,
    output logic [rv_pkg::xlen-1:0] commit_pc,
    output logic [4:0]              commit_rd,
    output logic [rv_pkg::xlen-1:0] commit_data,
    output logic                    commit_we
);

    import rv_pkg::*;

    alu_op_t         alu_op;
    logic [xlen-1:0] opb;
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] result;
    logic [xlen-1:0] target;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] npc;
    logic            taken;
    logic            writes_rd;
    logic            csr_we;
    logic            trap;
    logic            accept;

    assign dec_ready = 1'b1; // single-cycle execute that never stalls.
    assign accept    = dec_valid && dec_ready;
    assign opb       = (inst_type == type_r) ? src2 : imm;
    assign pc_plus4  = pc + xlen'(4);
    assign target    = pc + imm;

    always_comb begin
        case (funct3)
            f3_add:  alu_op = (inst_type == type_r && funct7[5]) ? alu_sub : alu_add;
            f3_xor:  alu_op = alu_xor;
            f3_or:   alu_op = alu_or;
            f3_and:  alu_op = alu_and;
            f3_slt:  alu_op = alu_slt;
            default: alu_op = alu_add;
        endcase
    end

    always_comb begin
        case (alu_op)
            alu_sub: alu_res = src1 - opb;
            alu_xor: alu_res = src1 ^ opb;
            alu_or:  alu_res = src1 | opb;
            alu_and: alu_res = src1 & opb;
            alu_slt: alu_res = {{(xlen-1){1'b0}}, $signed(src1) < $signed(opb)};
            default: alu_res = src1 + opb;
        endcase
    end

    assign taken = (funct3 == f3_beq) ? (src1 == src2) :
                   (funct3 == f3_bne) ? (src1 != src2) : 1'b0;

    always_comb begin
        result    = alu_res;
        writes_rd = 1'b0;
        csr_we    = 1'b0;
        csr_wdata = '0;
        trap      = 1'b0;
        npc       = pc_plus4;
        case (opcode)
            op_imm, op: writes_rd = 1'b1;
            lui: begin
                result    = imm;
                writes_rd = 1'b1;
            end
            auipc: begin
                result    = target;
                writes_rd = 1'b1;
            end
            jal: begin
                result    = pc_plus4; // link value.
                writes_rd = 1'b1;
                npc       = target;
            end
            branch: if (taken) npc = target;
            system: begin
                if (funct3 == f3_priv) begin
                    if (imm[11:0] == inst_mret[31:20]) begin
                        npc = mepc;
                    end else if (imm[11:0] == inst_ecall[31:20]) begin
                        trap = 1'b1;
                        npc  = mtvec;
                    end
                end else begin
                    result    = csr_r; // rd gets the old value.
                    writes_rd = 1'b1;
                    csr_we    = 1'b1;
                    case (funct3)
                        f3_csrrw:  csr_wdata = src1;
                        f3_csrrs:  csr_wdata = csr_r | src1;
                        f3_csrrwi: csr_wdata = imm;
                        default: begin
                            writes_rd = 1'b0;
                            csr_we    = 1'b0;
                        end
                    endcase
                end
            end
            default: ;
        endcase
    end

    assign srd       = result;
    assign gpr_w_en  = accept && writes_rd && (rd != 5'd0);
    assign csr_w_en  = accept && csr_we;
    assign is_intr   = accept && trap;
    assign intr_code = cause_ecall;
    assign redirect  = accept;
    assign next_pc   = npc;

    assign commit      = accept;
    assign commit_pc   = pc;
    assign commit_rd   = rd;
    assign commit_data = result;
    assign commit_we   = writes_rd && (rd != 5'd0);

    // targets stay word aligned because a misaligned fetch does not trap.
    assert property (@(posedge clk) disable iff (rst) redirect |-> next_pc[1:0] == 2'b00);

endmodule

/* hdl/ifu.sv */
`timescale 1ns/1ps

module ifu #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    redirect,
    input  logic [rv_pkg::xlen-1:0] next_pc,
    output logic [rv_pkg::xlen-1:0] inst_addr,
    input  logic [rv_pkg::xlen-1:0] inst_data,
    output logic                    inst_valid,
    input  logic                    inst_ready,
    output logic [rv_pkg::xlen-1:0] inst,
    output logic [rv_pkg::xlen-1:0] pc
);

    logic fetching; // pc is on inst_addr and the word arrives this cycle.

    assign inst_addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= reset_pc;
            fetching   <= 1'b1;
            inst_valid <= 1'b0;
        end else if (redirect) begin
            pc         <= next_pc;
            fetching   <= 1'b1;
            inst_valid <= 1'b0;
        end else if (fetching) begin
            fetching   <= 1'b0;
            inst_valid <= 1'b1;
        end else if (inst_valid && inst_ready) begin
            inst_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetching && !redirect) inst <= inst_data;
    end

    // the word must not change under a pending handshake.
    assert property (@(posedge clk) disable iff (rst)
        inst_valid && !inst_ready |=> $stable(inst) && $stable(pc));

endmodule

/* hdl/idu.sv */
`timescale 1ns/1ps

module idu (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       inst_valid,
    output logic                       inst_ready,
    output logic                       dec_valid,
    input  logic                       dec_ready,
    input  logic [rv_pkg::xlen-1:0]    inst,
    input  logic [rv_pkg::xlen-1:0]    pc,
    output rv_pkg::opcode_t            opcode,
    output logic [2:0]                 funct3,
    output logic [6:0]                 funct7,
    output rv_pkg::inst_type_t         inst_type,
    output logic [rv_pkg::xlen-1:0]    imm,
    output logic [rv_pkg::xlen-1:0]    src1,
    output logic [rv_pkg::xlen-1:0]    src2,
    output logic [4:0]                 rd,
    output logic [rv_pkg::xlen-1:0]    dec_pc,
    output logic [rv_pkg::xlen-1:0]    csr_r,
    output logic [rv_pkg::xlen-1:0]    mtvec,
    output logic [rv_pkg::xlen-1:0]    mepc,
    input  logic [rv_pkg::xlen-1:0]    srd,
    input  logic                       gpr_w_en,
    input  logic [rv_pkg::xlen-1:0]    csr_wdata,
    input  logic                       csr_w_en,
    input  logic                       is_intr,
    input  logic [rv_pkg::xlen-1:0]    intr_code
);

    import rv_pkg::*;

    logic [xlen-1:0] inst_q;

    // one instruction in flight until execute takes it.
    always_ff @(posedge clk) begin
        if (rst) inst_ready <= 1'b1;
        else if (inst_ready && inst_valid) inst_ready <= 1'b0;
        else if (dec_ready && dec_valid) inst_ready <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) dec_valid <= 1'b0;
        else if (dec_ready && dec_valid) dec_valid <= 1'b0;
        else if (inst_ready && inst_valid) dec_valid <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (inst_ready && inst_valid) begin
            inst_q <= inst;
            dec_pc <= pc;
        end
    end

    idu_core idu_core_inst (
        .clk      (clk),
        .rst      (rst),
        .inst     (inst_q),
        .pc       (dec_pc),
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7   (funct7),
        .inst_type(inst_type),
        .imm      (imm),
        .src1     (src1),
        .src2     (src2),
        .rd       (rd),
        .csr_r    (csr_r),
        .mtvec    (mtvec),
        .mepc     (mepc),
        .srd      (srd),
        .gpr_w_en (gpr_w_en),
        .csr_wdata(csr_wdata),
        .csr_w_en (csr_w_en),
        .is_intr  (is_intr),
        .intr_code(intr_code)
    );

    // write-back from execute only arrives in its accept cycle.
    assert property (@(posedge clk) disable iff (rst)
        (gpr_w_en || csr_w_en || is_intr) |-> dec_valid && dec_ready);

endmodule

/* hdl/idu_core.sv */
`timescale 1ns/1ps

module idu_core (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [rv_pkg::xlen-1:0] inst,
    input  logic [rv_pkg::xlen-1:0] pc,
    output rv_pkg::opcode_t         opcode,
    output logic [2:0]              funct3,
    output logic [6:0]              funct7,
    output rv_pkg::inst_type_t      inst_type,
    output logic [rv_pkg::xlen-1:0] imm,
    output logic [rv_pkg::xlen-1:0] src1,
    output logic [rv_pkg::xlen-1:0] src2,
    output logic [4:0]              rd,
    output logic [rv_pkg::xlen-1:0] csr_r,
    output logic [rv_pkg::xlen-1:0] mtvec,
    output logic [rv_pkg::xlen-1:0] mepc,
    input  logic [rv_pkg::xlen-1:0] srd,
    input  logic                    gpr_w_en,
    input  logic [rv_pkg::xlen-1:0] csr_wdata,
    input  logic                    csr_w_en,
    input  logic                    is_intr,
    input  logic [rv_pkg::xlen-1:0] intr_code
);

    import rv_pkg::*;

    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       is_csri;

    assign opcode = opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign is_csri = (opcode == system) && (funct3 == f3_csrrwi);

    always_comb begin
        case (opcode)
            op:         inst_type = type_r;
            lui, auipc: inst_type = type_u;
            jal:        inst_type = type_j;
            branch:     inst_type = type_b;
            default:    inst_type = type_i; // op_imm and system.
        endcase
    end

    always_comb begin
        case (inst_type)
            type_i:  imm = {{20{inst[31]}}, inst[31:20]};
            type_b:  imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            type_u:  imm = {inst[31:12], 12'b0};
            type_j:  imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
        if (is_csri) imm = {27'b0, rs1}; // zimm sits in the rs1 field.
    end

    gpr_file gpr_file_inst (
        .clk   (clk),
        .rst   (rst),
        .raddr1(rs1),
        .raddr2(rs2),
        .rdata1(src1),
        .rdata2(src2),
        .we    (gpr_w_en),
        .waddr (rd),
        .wdata (srd)
    );

    // csr address is the i-type field for csrrwi too.
    csr_file csr_file_inst (
        .clk       (clk),
        .rst       (rst),
        .addr      (inst[31:20]),
        .rdata     (csr_r),
        .we        (csr_w_en),
        .wdata     (csr_wdata),
        .trap      (is_intr),
        .trap_pc   (pc),
        .trap_cause(intr_code),
        .mtvec     (mtvec),
        .mepc      (mepc)
    );

endmodule

/* hdl/csr_file.sv */
`timescale 1ns/1ps

module csr_file (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [11:0]             addr,
    output logic [rv_pkg::xlen-1:0] rdata,
    input  logic                    we,
    input  logic [rv_pkg::xlen-1:0] wdata,
    input  logic                    trap,
    input  logic [rv_pkg::xlen-1:0] trap_pc,
    input  logic [rv_pkg::xlen-1:0] trap_cause,
    output logic [rv_pkg::xlen-1:0] mtvec,
    output logic [rv_pkg::xlen-1:0] mepc
);

    import rv_pkg::*;

    logic [xlen-1:0] mcause;

    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec  <= '0;
            mepc   <= '0;
            mcause <= '0;
        end else begin
            if (we) begin
                case (addr)
                    csr_mtvec:  mtvec  <= wdata;
                    csr_mepc:   mepc   <= wdata;
                    csr_mcause: mcause <= wdata;
                    default:    ;
                endcase
            end
            // trap update comes last and so wins over a software write.
            if (trap) begin
                mepc   <= trap_pc;
                mcause <= trap_cause;
            end
        end
    end

    always_comb begin
        case (addr)
            csr_mtvec:  rdata = mtvec;
            csr_mepc:   rdata = mepc;
            csr_mcause: rdata = mcause;
            default:    rdata = '0;
        endcase
    end

endmodule

/* hdl/gpr_file.sv */
`timescale 1ns/1ps

module gpr_file (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [4:0]              raddr1,
    input  logic [4:0]              raddr2,
    output logic [rv_pkg::xlen-1:0] rdata1,
    output logic [rv_pkg::xlen-1:0] rdata2,
    input  logic                    we,
    input  logic [4:0]              waddr,
    input  logic [rv_pkg::xlen-1:0] wdata
);

    import rv_pkg::*;

    logic [xlen-1:0] regs [0:31];

    // x0 is cleared by reset and never written, so it reads zero.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

/* hdl/rv_pkg.sv */
package rv_pkg;

    localparam int xlen = 32;

    // major opcodes of the supported subset.
    typedef enum logic [6:0] {
        op_imm = 7'b0010011,
        op     = 7'b0110011,
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        jal    = 7'b1101111,
        branch = 7'b1100011,
        system = 7'b1110011
    } opcode_t;

    typedef enum logic [2:0] {
        type_r,
        type_i,
        type_s,
        type_b,
        type_u,
        type_j
    } inst_type_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_xor,
        alu_or,
        alu_and,
        alu_slt
    } alu_op_t;

    localparam logic [2:0] f3_add    = 3'b000;
    localparam logic [2:0] f3_xor    = 3'b100;
    localparam logic [2:0] f3_or     = 3'b110;
    localparam logic [2:0] f3_and    = 3'b111;
    localparam logic [2:0] f3_slt    = 3'b010;
    localparam logic [2:0] f3_beq    = 3'b000;
    localparam logic [2:0] f3_bne    = 3'b001;
    localparam logic [2:0] f3_csrrw  = 3'b001;
    localparam logic [2:0] f3_csrrs  = 3'b010;
    localparam logic [2:0] f3_csrrwi = 3'b101;
    localparam logic [2:0] f3_priv   = 3'b000; // ecall and mret.

    localparam logic [11:0] csr_mtvec  = 12'h305;
    localparam logic [11:0] csr_mepc   = 12'h341;
    localparam logic [11:0] csr_mcause = 12'h342;

    localparam logic [xlen-1:0] cause_ecall = 32'd11; // ecall from m-mode.

    localparam logic [31:0] inst_ecall = 32'h0000_0073;
    localparam logic [31:0] inst_mret  = 32'h3020_0073;

endpackage
